// ==== compile.f ====
hw/mem_access_pkg.sv
hw/lsq_pkg.sv
hw/cdb_snoop.sv
hw/agu.sv
hw/lsq_queue.sv
hw/load_align.sv
hw/lsq_head_ctrl.sv
hw/lsq_top.sv
testbench/lsq_assertions.sv
testbench/lsq_tb.sv

// ==== hw/agu.sv ====
module agu (
    input  mem_access_pkg::word_t      base,
    input  mem_access_pkg::word_t      imm,
    input  mem_access_pkg::funct3_t    funct3,
    input  logic                       is_store,
    input  mem_access_pkg::word_t      store_data,
    output mem_access_pkg::word_t      addr,
    output mem_access_pkg::byte_mask_t mask,
    output mem_access_pkg::word_t      wdata
);

    mem_access_pkg::word_t sum;
    logic [1:0]            offset;

    assign sum = base + imm;
    assign offset = sum[1:0];

    // word aligned, lanes picked by the mask
    assign addr = {sum[31:2], 2'b00};

    always_comb begin
        // sb and sh encode like lb and lh, so one case covers both kinds
        case (funct3)
            mem_access_pkg::lb, mem_access_pkg::lbu: mask = mem_access_pkg::mask_byte << offset;
            mem_access_pkg::lh, mem_access_pkg::lhu: mask = mem_access_pkg::mask_half << offset;
            mem_access_pkg::lw:                      mask = mem_access_pkg::mask_word;
            default:                                 mask = '0;
        endcase
    end

    always_comb begin
        wdata = '0;
        if (is_store) begin
            case (funct3)
                mem_access_pkg::sb: wdata = {24'b0, store_data[7:0]} << {offset, 3'b000};
                // half moves to the upper lanes on offset bit 1 only
                mem_access_pkg::sh: wdata = {16'b0, store_data[15:0]} << {offset[1], 4'b0000};
                mem_access_pkg::sw: wdata = store_data;
                default:            wdata = '0;
            endcase
        end
    end

endmodule

// ==== hw/cdb_snoop.sv ====
module cdb_snoop #(
    parameter int num_cdb = 2
) (
    input  lsq_pkg::rob_tag_t     wait_tag,
    input  logic                  waiting,
    input  lsq_pkg::cdb_t         cdb [num_cdb],
    output logic                  hit,
    output mem_access_pkg::word_t value
);

    always_comb begin
        hit = 1'b0;
        value = '0;
        // walk downward so the lowest matching port is written last and wins
        for (int i = num_cdb - 1; i >= 0; i--) begin
            if (waiting && cdb[i].valid && (cdb[i].tag == wait_tag)) begin
                hit = 1'b1;
                value = cdb[i].value;
            end
        end
    end

endmodule

// ==== hw/load_align.sv ====
module load_align (
    input  mem_access_pkg::word_t   word,
    input  logic [1:0]              offset,
    input  mem_access_pkg::funct3_t funct3,
    output mem_access_pkg::word_t   data
);

    logic [7:0]  lane_byte;
    logic [15:0] lane_half;

    assign lane_byte = word[{offset, 3'b000} +: 8];
    // halves sit on even bytes, bit 1 picks which one
    assign lane_half = word[{offset[1], 4'b0000} +: 16];

    always_comb begin
        case (funct3)
            mem_access_pkg::lb:  data = {{24{lane_byte[7]}}, lane_byte};
            mem_access_pkg::lbu: data = {24'b0, lane_byte};
            mem_access_pkg::lh:  data = {{16{lane_half[15]}}, lane_half};
            mem_access_pkg::lhu: data = {16'b0, lane_half};
            mem_access_pkg::lw:  data = word;
            default:             data = word;
        endcase
    end

endmodule

// ==== hw/lsq_head_ctrl.sv ====
module lsq_head_ctrl (
    input  lsq_pkg::lsq_entry_t   head,
    input  logic                  head_valid,
    input  logic                  flush,
    input  mem_access_pkg::word_t mem_rdata,
    input  logic                  mem_ready,
    output logic                  mem_read,
    output mem_access_pkg::word_t mem_addr,
    output logic                  result_valid,
    output lsq_pkg::lsq_result_t  result,
    output logic                  dequeue
);

    logic                  issue;
    logic [1:0]            offset;
    mem_access_pkg::word_t load_data;

    // head can act once its address is written back
    assign issue = head_valid && head.addr_done && !flush;

    assign mem_read = issue && head.is_load;
    assign mem_addr = head.addr;

    // stores retire at once, loads wait for the memory strobe
    assign result_valid = issue && (head.is_store || (head.is_load && mem_ready));
    assign dequeue = result_valid;

    // byte offset is lost in the aligned address
    assign offset = head.rs1_value[1:0] + head.imm[1:0];

    load_align load_align_inst (
        .word   (mem_rdata),
        .offset (offset),
        .funct3 (head.funct3),
        .data   (load_data)
    );

    always_comb begin
        result.rob_tag = head.rob_tag;
        result.is_store = head.is_store;
        result.addr = head.addr;
        result.mask = head.mask;
        result.wdata = head.wdata;
        result.load_data = head.is_load ? load_data : '0;
    end

endmodule

// ==== hw/lsq_pkg.sv ====
package lsq_pkg;

    localparam int rob_tag_width = 5;

    typedef logic [rob_tag_width-1:0] rob_tag_t;

    // one common data bus beat
    typedef struct packed {
        logic                  valid;
        rob_tag_t              tag;
        mem_access_pkg::word_t value;
    } cdb_t;

    // memory operation as it leaves dispatch
    typedef struct packed {
        logic                    valid;
        logic                    is_load;
        logic                    is_store;
        mem_access_pkg::funct3_t funct3;
        rob_tag_t                rob_tag;
        mem_access_pkg::word_t   imm;
        logic                    rs1_ready;
        rob_tag_t                rs1_tag;
        mem_access_pkg::word_t   rs1_value;
        logic                    rs2_ready;
        rob_tag_t                rs2_tag;
        mem_access_pkg::word_t   rs2_value;
    } dispatch_t;

    typedef struct packed {
        logic                       valid;
        logic                       is_load;
        logic                       is_store;
        mem_access_pkg::funct3_t    funct3;
        rob_tag_t                   rob_tag;
        mem_access_pkg::word_t      imm;
        logic                       rs1_ready;
        rob_tag_t                   rs1_tag;
        mem_access_pkg::word_t      rs1_value;
        logic                       rs2_ready;
        rob_tag_t                   rs2_tag;
        mem_access_pkg::word_t      rs2_value;
        // filled in by the address write-back
        logic                       addr_done;
        mem_access_pkg::word_t      addr;
        mem_access_pkg::byte_mask_t mask;
        mem_access_pkg::word_t      wdata;
    } lsq_entry_t;

    // completed operation toward the reorder buffer
    typedef struct packed {
        rob_tag_t                   rob_tag;
        logic                       is_store;
        mem_access_pkg::word_t      addr;
        mem_access_pkg::byte_mask_t mask;
        mem_access_pkg::word_t      wdata;
        mem_access_pkg::word_t      load_data;
    } lsq_result_t;

endpackage

// ==== hw/lsq_queue.sv ====
module lsq_queue #(
    parameter int lsq_depth = 8,
    parameter int num_cdb   = 2
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       flush,
    input  lsq_pkg::dispatch_t         dispatch,
    input  lsq_pkg::cdb_t              cdb [num_cdb],
    input  mem_access_pkg::word_t      agu_addr [lsq_depth],
    input  mem_access_pkg::byte_mask_t agu_mask [lsq_depth],
    input  mem_access_pkg::word_t      agu_wdata [lsq_depth],
    input  logic                       dequeue,
    output logic                       full,
    output lsq_pkg::lsq_entry_t        entries [lsq_depth],
    output lsq_pkg::lsq_entry_t        head,
    output logic                       head_valid
);

    // extra top bit tells full from empty
    localparam int ptr_width = $clog2(lsq_depth) + 1;

    logic [ptr_width-1:0]  head_ptr;
    logic [ptr_width-1:0]  tail_ptr;
    logic                  same_idx;
    logic                  empty;
    logic                  enqueue;
    lsq_pkg::lsq_entry_t   new_entry;
    logic                  disp_rs1_hit;
    logic                  disp_rs2_hit;
    mem_access_pkg::word_t disp_rs1_value;
    mem_access_pkg::word_t disp_rs2_value;
    logic [lsq_depth-1:0]  rs1_hit;
    logic [lsq_depth-1:0]  rs2_hit;
    mem_access_pkg::word_t rs1_value [lsq_depth];
    mem_access_pkg::word_t rs2_value [lsq_depth];
    logic [lsq_depth-1:0]  addr_ready;

    assign same_idx = head_ptr[ptr_width-2:0] == tail_ptr[ptr_width-2:0];
    assign full = same_idx && (head_ptr[ptr_width-1] != tail_ptr[ptr_width-1]);
    assign empty = same_idx && (head_ptr[ptr_width-1] == tail_ptr[ptr_width-1]);
    assign enqueue = dispatch.valid && !full && !flush;

    assign head = entries[head_ptr[ptr_width-2:0]];
    assign head_valid = !empty && head.valid;

    // operands broadcast in the dispatch cycle
    cdb_snoop #(.num_cdb(num_cdb)) disp_rs1_snoop (
        .wait_tag (dispatch.rs1_tag),
        .waiting  (dispatch.valid && !dispatch.rs1_ready),
        .cdb      (cdb),
        .hit      (disp_rs1_hit),
        .value    (disp_rs1_value)
    );

    cdb_snoop #(.num_cdb(num_cdb)) disp_rs2_snoop (
        .wait_tag (dispatch.rs2_tag),
        .waiting  (dispatch.valid && !dispatch.rs2_ready),
        .cdb      (cdb),
        .hit      (disp_rs2_hit),
        .value    (disp_rs2_value)
    );

    for (genvar i = 0; i < lsq_depth; i++) begin : g_entry
        cdb_snoop #(.num_cdb(num_cdb)) rs1_snoop (
            .wait_tag (entries[i].rs1_tag),
            .waiting  (entries[i].valid && !entries[i].rs1_ready),
            .cdb      (cdb),
            .hit      (rs1_hit[i]),
            .value    (rs1_value[i])
        );

        cdb_snoop #(.num_cdb(num_cdb)) rs2_snoop (
            .wait_tag (entries[i].rs2_tag),
            .waiting  (entries[i].valid && !entries[i].rs2_ready),
            .cdb      (cdb),
            .hit      (rs2_hit[i]),
            .value    (rs2_value[i])
        );

        // loads only need the base, stores need the data as well
        assign addr_ready[i] = entries[i].valid && !entries[i].addr_done &&
                               entries[i].rs1_ready &&
                               (entries[i].is_load || entries[i].rs2_ready);
    end

    always_comb begin
        new_entry = '0;
        new_entry.valid = 1'b1;
        new_entry.is_load = dispatch.is_load;
        new_entry.is_store = dispatch.is_store;
        new_entry.funct3 = dispatch.funct3;
        new_entry.rob_tag = dispatch.rob_tag;
        new_entry.imm = dispatch.imm;
        new_entry.rs1_ready = dispatch.rs1_ready || disp_rs1_hit;
        new_entry.rs1_tag = dispatch.rs1_tag;
        new_entry.rs1_value = disp_rs1_hit ? disp_rs1_value : dispatch.rs1_value;
        new_entry.rs2_ready = dispatch.rs2_ready || disp_rs2_hit;
        new_entry.rs2_tag = dispatch.rs2_tag;
        new_entry.rs2_value = disp_rs2_hit ? disp_rs2_value : dispatch.rs2_value;
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            for (int i = 0; i < lsq_depth; i++) begin
                entries[i] <= '0;
            end
        end else begin
            for (int i = 0; i < lsq_depth; i++) begin
                if (rs1_hit[i]) begin
                    entries[i].rs1_ready <= 1'b1;
                    entries[i].rs1_value <= rs1_value[i];
                end
                if (rs2_hit[i]) begin
                    entries[i].rs2_ready <= 1'b1;
                    entries[i].rs2_value <= rs2_value[i];
                end
                // address write-back, one cycle after the operands settle
                if (addr_ready[i]) begin
                    entries[i].addr_done <= 1'b1;
                    entries[i].addr <= agu_addr[i];
                    entries[i].mask <= agu_mask[i];
                    entries[i].wdata <= agu_wdata[i];
                end
            end
            if (enqueue) begin
                entries[tail_ptr[ptr_width-2:0]] <= new_entry;
                tail_ptr <= tail_ptr + 1'b1;
            end
            if (dequeue) begin
                entries[head_ptr[ptr_width-2:0]] <= '0;
                head_ptr <= head_ptr + 1'b1;
            end
        end
    end

endmodule

// ==== hw/lsq_top.sv ====
module lsq_top #(
    parameter int lsq_depth = 8,
    parameter int num_cdb   = 2
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  lsq_pkg::dispatch_t    dispatch,
    input  lsq_pkg::cdb_t         cdb [num_cdb],
    input  mem_access_pkg::word_t mem_rdata,
    input  logic                  mem_ready,
    output logic                  full,
    output logic                  mem_read,
    output mem_access_pkg::word_t mem_addr,
    output logic                  result_valid,
    output lsq_pkg::lsq_result_t  result
);

    lsq_pkg::lsq_entry_t        entries [lsq_depth];
    lsq_pkg::lsq_entry_t        head;
    logic                       head_valid;
    logic                       dequeue;
    mem_access_pkg::word_t      agu_addr [lsq_depth];
    mem_access_pkg::byte_mask_t agu_mask [lsq_depth];
    mem_access_pkg::word_t      agu_wdata [lsq_depth];

    lsq_queue #(
        .lsq_depth (lsq_depth),
        .num_cdb   (num_cdb)
    ) lsq_queue_inst (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .dispatch   (dispatch),
        .cdb        (cdb),
        .agu_addr   (agu_addr),
        .agu_mask   (agu_mask),
        .agu_wdata  (agu_wdata),
        .dequeue    (dequeue),
        .full       (full),
        .entries    (entries),
        .head       (head),
        .head_valid (head_valid)
    );

    // one address generator per entry so all slots resolve in parallel
    for (genvar i = 0; i < lsq_depth; i++) begin : g_agu
        agu agu_inst (
            .base       (entries[i].rs1_value),
            .imm        (entries[i].imm),
            .funct3     (entries[i].funct3),
            .is_store   (entries[i].is_store),
            .store_data (entries[i].rs2_value),
            .addr       (agu_addr[i]),
            .mask       (agu_mask[i]),
            .wdata      (agu_wdata[i])
        );
    end

    lsq_head_ctrl lsq_head_ctrl_inst (
        .head         (head),
        .head_valid   (head_valid),
        .flush        (flush),
        .mem_rdata    (mem_rdata),
        .mem_ready    (mem_ready),
        .mem_read     (mem_read),
        .mem_addr     (mem_addr),
        .result_valid (result_valid),
        .result       (result),
        .dequeue      (dequeue)
    );

endmodule

// ==== hw/mem_access_pkg.sv ====
package mem_access_pkg;

    typedef logic [31:0] word_t;

    // one enable per byte lane
    typedef logic [3:0] byte_mask_t;

    // RV32I funct3 for loads and stores
    typedef logic [2:0] funct3_t;

    // loads
    localparam funct3_t lb  = 3'b000;
    localparam funct3_t lh  = 3'b001;
    localparam funct3_t lw  = 3'b010;
    localparam funct3_t lbu = 3'b100;
    localparam funct3_t lhu = 3'b101;

    // stores share the low two bits with the signed loads
    localparam funct3_t sb = 3'b000;
    localparam funct3_t sh = 3'b001;
    localparam funct3_t sw = 3'b010;

    // lane patterns before the offset shift
    localparam byte_mask_t mask_byte = 4'b0001;
    localparam byte_mask_t mask_half = 4'b0011;
    localparam byte_mask_t mask_word = 4'b1111;

endpackage

// ==== run.sh ====
#!/bin/sh
# build and run the load/store queue testbench with Verilator
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --top-module lsq_tb -f compile.f -o lsq_sim \
    && ./obj_dir/lsq_sim \
    || { echo "simulation failed"; exit 1; }

// ==== testbench/lsq_assertions.sv ====
module lsq_assertions (
    input logic               clk,
    input logic               reset,
    input logic               flush,
    input lsq_pkg::dispatch_t dispatch,
    input logic               full,
    input logic               mem_read,
    input logic               result_valid
);

    logic load_seen;
    logic any_seen;

    // accepted dispatches since the last reset
    always_ff @(posedge clk) begin
        if (reset) begin
            load_seen <= 1'b0;
            any_seen <= 1'b0;
        end else if (dispatch.valid && !full && !flush) begin
            any_seen <= 1'b1;
            if (dispatch.is_load) begin
                load_seen <= 1'b1;
            end
        end
    end

    no_result_in_flush: assert property (@(posedge clk) disable iff (reset)
        flush |-> !result_valid)
        else $error("result_valid high in a flush cycle");

    no_read_before_load: assert property (@(posedge clk) disable iff (reset)
        !load_seen |-> !mem_read)
        else $error("mem_read high before any load was dispatched");

    nothing_before_dispatch: assert property (@(posedge clk) disable iff (reset)
        !any_seen |-> (!result_valid && !full))
        else $error("result_valid or full high before any dispatch");

endmodule

// ==== testbench/lsq_tb.sv ====
module lsq_tb;

    localparam int lsq_depth = 8;
    localparam int num_cdb = 2;
    localparam int reset_cycles = 16;
    localparam int cycles_per_test = 40;

    // one line of the test file
    typedef struct {
        string                name;
        string                op;
        logic [2:0]           funct3;
        logic [4:0]           rob_tag;
        logic [31:0]          imm;
        logic [31:0]          base;
        logic [31:0]          store_data;
        int                   rs1_when;
        int                   rs1_port;
        int                   rs2_when;
        int                   rs2_port;
        logic [31:0]          mem_word;
        int                   cycles;
        lsq_pkg::lsq_result_t expected;
    } test_line_t;

    logic                  clk;
    logic                  reset;
    logic                  flush;
    lsq_pkg::dispatch_t    dispatch;
    lsq_pkg::cdb_t         cdb [num_cdb];
    mem_access_pkg::word_t mem_rdata;
    logic                  mem_ready;
    logic                  full;
    logic                  mem_read;
    mem_access_pkg::word_t mem_addr;
    logic                  result_valid;
    lsq_pkg::lsq_result_t  result;

    test_line_t            tests [$];
    lsq_pkg::lsq_result_t  expected_q [$];
    string                 name_q [$];
    mem_access_pkg::word_t mem_word_q [$];
    string                 load_name_q [$];
    mem_access_pkg::word_t load_addr_q [$];
    int                    hold_cycles;
    int                    wait_left;
    logic                  saw_full;
    logic                  loaded;
    integer                seed;

    lsq_top #(
        .lsq_depth (lsq_depth),
        .num_cdb   (num_cdb)
    ) lsq_top_inst (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .dispatch     (dispatch),
        .cdb          (cdb),
        .mem_rdata    (mem_rdata),
        .mem_ready    (mem_ready),
        .full         (full),
        .mem_read     (mem_read),
        .mem_addr     (mem_addr),
        .result_valid (result_valid),
        .result       (result)
    );

    bind lsq_top lsq_assertions lsq_assertions_inst (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .dispatch     (dispatch),
        .full         (full),
        .mem_read     (mem_read),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic stop_with_failure();
        $display("Finished with errors");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_equal(string test_name, logic [127:0] expected, logic [127:0] actual);
        if (expected !== actual) begin
            $display("Mismatch in %s: expected %h, actual %h", test_name, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic read_tests();
        int          fd;
        int          count;
        string       line;
        string       name;
        string       op;
        logic [2:0]  funct3;
        logic [4:0]  rob_tag;
        logic [31:0] imm;
        logic [31:0] base;
        logic [31:0] store_data;
        int          rs1_when;
        int          rs1_port;
        int          rs2_when;
        int          rs2_port;
        logic [31:0] mem_word;
        logic [31:0] exp_addr;
        logic [3:0]  exp_mask;
        logic [31:0] exp_wdata;
        logic [31:0] exp_load;
        int          cycles;
        test_line_t  t;
        fd = $fopen("testbench/lsq_tests.txt", "r");
        if (fd == 0) begin
            $display("Cannot open the test file testbench/lsq_tests.txt");
            stop_with_failure();
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line.getc(0) == "#") begin
                    continue;
                end
                count = $sscanf(line, "%s %s", name, op);
                cycles = 0;
                if (op == "ld" || op == "st") begin
                    count = $sscanf(line, "%s %s %h %h %h %h %h %d %d %d %d %h %h %h %h %h",
                                    name, op, funct3, rob_tag, imm, base, store_data,
                                    rs1_when, rs1_port, rs2_when, rs2_port, mem_word,
                                    exp_addr, exp_mask, exp_wdata, exp_load);
                end else if (op == "hold") begin
                    count = $sscanf(line, "%s %s %d", name, op, cycles) + 13;
                end else begin
                    count = 16;
                end
                if (count != 16) begin
                    $display("Malformed line in the test file: %s", line);
                    stop_with_failure();
                end else begin
                    t.name = name;
                    t.op = op;
                    t.funct3 = funct3;
                    t.rob_tag = rob_tag;
                    t.imm = imm;
                    t.base = base;
                    t.store_data = store_data;
                    t.rs1_when = rs1_when;
                    t.rs1_port = rs1_port;
                    t.rs2_when = rs2_when;
                    t.rs2_port = rs2_port;
                    t.mem_word = mem_word;
                    t.cycles = cycles;
                    t.expected.rob_tag = rob_tag;
                    t.expected.is_store = (op == "st");
                    t.expected.addr = exp_addr;
                    t.expected.mask = exp_mask;
                    t.expected.wdata = exp_wdata;
                    t.expected.load_data = exp_load;
                    tests.push_back(t);
                end
            end
            $fclose(fd);
        end
    endtask

    // memory answers a pending read after 0 to 3 cycles unless held
    task automatic step_memory();
        string load_name;
        mem_ready = 1'b0;
        if (hold_cycles > 0) begin
            hold_cycles--;
        end else if (mem_read) begin
            if (wait_left < 0) begin
                wait_left = $unsigned($random(seed)) % 4;
            end
            if (wait_left == 0) begin
                if (mem_word_q.size() == 0) begin
                    $display("Memory read at %h with no load outstanding", mem_addr);
                    stop_with_failure();
                end else begin
                    // the head load reads its own aligned address
                    load_name = load_name_q.pop_front();
                    check_equal({load_name, " mem_addr"}, 128'(load_addr_q.pop_front()),
                                128'(mem_addr));
                    mem_ready = 1'b1;
                    mem_rdata = mem_word_q.pop_front();
                    wait_left = -1;
                end
            end else begin
                wait_left--;
            end
        end else begin
            wait_left = -1;
        end
    endtask

    task automatic next_cycle();
        @(negedge clk);
        step_memory();
        flush = 1'b0;
        dispatch = '0;
        for (int i = 0; i < num_cdb; i++) begin
            cdb[i] = '0;
        end
    endtask

    task automatic drive_beats(test_line_t t, int c);
        logic [num_cdb-1:0] used;
        used = '0;
        if (t.rs1_when == c) begin
            cdb[t.rs1_port] = '{valid: 1'b1, tag: t.rob_tag ^ 5'h10, value: t.base};
            used[t.rs1_port] = 1'b1;
        end
        if (t.op == "st" && t.rs2_when == c) begin
            cdb[t.rs2_port] = '{valid: 1'b1, tag: t.rob_tag ^ 5'h08, value: t.store_data};
            used[t.rs2_port] = 1'b1;
        end
        // idle ports carry a tag nobody waits for
        for (int i = 0; i < num_cdb; i++) begin
            if (!used[i]) begin
                cdb[i] = '{valid: 1'b1, tag: t.rob_tag ^ 5'h1f, value: $random(seed)};
            end
        end
    endtask

    task automatic run_operation(test_line_t t);
        lsq_pkg::dispatch_t d;
        int                 last;
        d = '0;
        d.valid = 1'b1;
        d.is_load = (t.op == "ld");
        d.is_store = (t.op == "st");
        d.funct3 = t.funct3;
        d.rob_tag = t.rob_tag;
        d.imm = t.imm;
        d.rs1_tag = t.rob_tag ^ 5'h10;
        d.rs1_ready = (t.rs1_when < 0);
        // a late operand carries a wrong value until its beat arrives
        d.rs1_value = d.rs1_ready ? t.base : ~t.base;
        d.rs2_tag = t.rob_tag ^ 5'h08;
        d.rs2_ready = d.is_load || (t.rs2_when < 0);
        d.rs2_value = d.rs2_ready ? t.store_data : ~t.store_data;
        last = 0;
        if (t.rs1_when > last) begin
            last = t.rs1_when;
        end
        if (d.is_store && t.rs2_when > last) begin
            last = t.rs2_when;
        end
        next_cycle();
        while (full) begin
            saw_full = 1'b1;
            next_cycle();
        end
        dispatch = d;
        expected_q.push_back(t.expected);
        name_q.push_back(t.name);
        if (d.is_load) begin
            mem_word_q.push_back(t.mem_word);
            load_name_q.push_back(t.name);
            load_addr_q.push_back(t.expected.addr);
        end
        for (int c = 0; c <= last; c++) begin
            if (c > 0) begin
                next_cycle();
            end
            drive_beats(t, c);
        end
    endtask

    task automatic run_flush(test_line_t t);
        lsq_pkg::dispatch_t filler;
        filler = '0;
        filler.valid = 1'b1;
        filler.is_load = 1'b1;
        filler.funct3 = mem_access_pkg::lw;
        filler.rs1_ready = 1'b1;
        filler.rs2_ready = 1'b1;
        repeat (3) next_cycle();
        // fill the free slots so the flush has to lower full
        while (!full) begin
            dispatch = filler;
            next_cycle();
        end
        check_equal({t.name, " mem_read before flush"}, 128'(1'b1), 128'(mem_read));
        flush = 1'b1;
        // a reply in the flush cycle must not complete the head load
        mem_ready = 1'b1;
        mem_rdata = '1;
        expected_q.delete();
        name_q.delete();
        mem_word_q.delete();
        load_name_q.delete();
        load_addr_q.delete();
        hold_cycles = 0;
        wait_left = -1;
        next_cycle();
        check_equal({t.name, " full after flush"}, 128'(1'b0), 128'(full));
        check_equal({t.name, " mem_read after flush"}, 128'(1'b0), 128'(mem_read));
    endtask

    task automatic drain_results();
        while (expected_q.size() != 0) begin
            next_cycle();
        end
    endtask

    initial begin
        seed = 32'h9d3cd9da;
        loaded = 1'b0;
        reset = 1'b1;
        flush = 1'b0;
        dispatch = '0;
        for (int i = 0; i < num_cdb; i++) begin
            cdb[i] = '0;
        end
        mem_rdata = '0;
        mem_ready = 1'b0;
        hold_cycles = 0;
        wait_left = -1;
        saw_full = 1'b0;
        read_tests();
        loaded = 1'b1;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        foreach (tests[i]) begin
            if (tests[i].op == "hold") begin
                // start from an empty queue so the hold covers only what follows
                drain_results();
                hold_cycles = tests[i].cycles;
                saw_full = 1'b0;
            end else if (tests[i].op == "full") begin
                check_equal(tests[i].name, 128'(1'b1), 128'(saw_full));
            end else if (tests[i].op == "flush") begin
                run_flush(tests[i]);
            end else begin
                run_operation(tests[i]);
            end
        end
        drain_results();
        repeat (10) next_cycle();
        $display("Finished with no errors");
        $finish;
    end

    // results leave in dispatch order
    always @(posedge clk) begin
        if (!reset && result_valid) begin
            if (expected_q.size() == 0) begin
                $display("Result for ROB tag %0d with no operation outstanding", result.rob_tag);
                stop_with_failure();
            end else begin
                check_equal(name_q.pop_front(), 128'(expected_q.pop_front()), 128'(result));
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (reset_cycles + cycles_per_test * tests.size()) @(posedge clk);
        $display("Timeout: the tests did not finish in %0d cycles",
                 reset_cycles + cycles_per_test * tests.size());
        stop_with_failure();
    end

endmodule

// ==== testbench/lsq_tests.txt ====
# name op funct3 tag imm base sdata rs1_when rs1_port rs2_when rs2_port mem addr mask wdata load
# when: -1 ready at dispatch, n beat n cycles after dispatch; other ops: hold <cycles>, full, flush
sb_off0 st 0 01 00000000 00001000 a1b2c3d4 -1 0 -1 0 00000000 00001000 1 000000d4 00000000
sb_off1 st 0 02 00000001 00001000 a1b2c3d4 -1 0 -1 0 00000000 00001000 2 0000d400 00000000
sb_off2 st 0 03 00000006 00001000 a1b2c3d4 2 1 0 0 00000000 00001004 4 00d40000 00000000
sb_off3 st 0 04 ffffffff 00001004 a1b2c3d4 -1 0 3 1 00000000 00001000 8 d4000000 00000000
sh_off0 st 1 05 00000000 00002000 a1b2c3d4 0 1 -1 0 00000000 00002000 3 0000c3d4 00000000
sh_off2 st 1 06 00000002 00002000 a1b2c3d4 1 0 1 1 00000000 00002000 c c3d40000 00000000
sw_word st 2 07 fffffffc 00003008 a1b2c3d4 -1 0 2 0 00000000 00003004 f a1b2c3d4 00000000
lb_off2 ld 0 08 00000002 00004000 00000000 -1 0 -1 0 80f17f02 00004000 4 00000000 fffffff1
lbu_off3 ld 4 09 00000003 00004000 00000000 0 0 -1 0 80f17f02 00004000 8 00000000 00000080
lb_off1 ld 0 0a 00000001 00004000 00000000 2 1 -1 0 80f17f02 00004000 2 00000000 0000007f
lh_off0 ld 1 0b 00000000 00004000 00000000 -1 0 -1 0 80f17f02 00004000 3 00000000 00007f02
lh_off2 ld 1 0c 00000006 00003ffc 00000000 1 1 -1 0 80f17f02 00004000 c 00000000 ffff80f1
lhu_off2 ld 5 0d 00000002 00004000 00000000 -1 0 -1 0 80f17f02 00004000 c 00000000 000080f1
lw_word ld 2 0e 00000008 00004000 00000000 -1 0 -1 0 80f17f02 00004008 f 00000000 80f17f02
ord_hold hold 6
ord_ld ld 4 0f 00000001 00006000 00000000 -1 0 -1 0 12345678 00006000 2 00000000 00000056
ord_st st 0 10 00000003 00006000 000000ee -1 0 -1 0 00000000 00006000 8 ee000000 00000000
bp_hold hold 20
bp_ld0 ld 2 11 00000000 00005000 00000000 -1 0 -1 0 11111111 00005000 f 00000000 11111111
bp_ld1 ld 2 12 00000000 00005000 00000000 -1 0 -1 0 22222222 00005000 f 00000000 22222222
bp_ld2 ld 2 13 00000000 00005000 00000000 -1 0 -1 0 33333333 00005000 f 00000000 33333333
bp_ld3 ld 2 14 00000000 00005000 00000000 -1 0 -1 0 44444444 00005000 f 00000000 44444444
bp_ld4 ld 2 15 00000000 00005000 00000000 -1 0 -1 0 55555555 00005000 f 00000000 55555555
bp_ld5 ld 2 16 00000000 00005000 00000000 -1 0 -1 0 66666666 00005000 f 00000000 66666666
bp_ld6 ld 2 17 00000000 00005000 00000000 -1 0 -1 0 77777777 00005000 f 00000000 77777777
bp_ld7 ld 2 18 00000000 00005000 00000000 -1 0 -1 0 88888888 00005000 f 00000000 88888888
bp_ld8 ld 2 19 00000000 00005000 00000000 -1 0 -1 0 99999999 00005000 f 00000000 99999999
bp_full full
fl_hold hold 100
fl_ld0 ld 2 1a 00000000 00007000 00000000 -1 0 -1 0 cafef00d 00007000 f 00000000 cafef00d
fl_ld1 ld 0 1b 00000001 00007000 00000000 -1 0 -1 0 cafef00d 00007000 2 00000000 fffffff0
fl_st st 1 1c 00000002 00007000 00005a5a -1 0 -1 0 00000000 00007000 c 5a5a0000 00000000
fl_flush flush
post_sh st 1 1d 00000000 00008000 0000beef -1 0 1 1 00000000 00008000 3 0000beef 00000000
post_lbu ld 4 1e 00000002 00008000 00000000 -1 0 -1 0 00a50000 00008000 4 00000000 000000a5
